// File: rtl/bank_sram.sv
/*
 * Codeword storage array
 * Single port, BankSize words of 39 bits, write or read per request,
 * read data registered and valid the cycle after the request
 */

`default_nettype none

module bank_sram (
  input  logic                 clk_i,
  input  logic                 req_i,
  input  logic                 we_i,
  input  tcdm_pkg::bank_addr_t addr_i,
  input  ecc_pkg::codeword_t   wdata_i,
  output ecc_pkg::codeword_t   rdata_o
);

  import tcdm_pkg::*;
  import ecc_pkg::*;

  codeword_t mem_q [BankSize];  // Storage, undefined until written
  codeword_t rdata_q;           // Read register, holds until next read

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      if (we_i) begin
        mem_q[addr_i] <= wdata_i;
      end else begin
        rdata_q <= mem_q[addr_i];
      end
    end
  end

  assign rdata_o = rdata_q;

endmodule

`default_nettype wire

// File: rtl/ecc_pkg.sv
/*
 * SECDED code definitions
 * Hsiao (39,32) codeword layout, syndrome width, parity-check columns
 * and the state encodings of the bank and scrubber FSMs
 */

`default_nettype none

package ecc_pkg;

  localparam int unsigned CheckWidth     = 7;
  localparam int unsigned ProtectedWidth = tcdm_pkg::DataWidth + CheckWidth; // 39

  // Check bits on top, data in [31:0]
  typedef logic [ProtectedWidth-1:0] codeword_t;
  typedef logic [CheckWidth-1:0]     syndrome_t;

  // Parity-check columns of the data bits, all weight 3
  // Check bits use the unit columns, so every column is odd weight
  localparam syndrome_t [tcdm_pkg::DataWidth-1:0] HsiaoCols = {
    7'h38, 7'h64, 7'h54, 7'h34, 7'h4c, 7'h2c, 7'h1c, 7'h62,  // 31..24
    7'h52, 7'h32, 7'h4a, 7'h2a, 7'h1a, 7'h46, 7'h26, 7'h16,  // 23..16
    7'h0e, 7'h61, 7'h51, 7'h31, 7'h49, 7'h29, 7'h19, 7'h45,  // 15..8
    7'h25, 7'h15, 7'h0d, 7'h43, 7'h23, 7'h13, 7'h0b, 7'h07   // 7..0
  };

  // Bank FSM
  typedef enum logic [1:0] {
    IDLE,       // Bus or scrubber read
    RMW_MERGE,  // Old word back, merged word written
    SCRUB_FIX   // Array owned by scrubber check/write-back
  } ecc_state_e;

  // Scrubber FSM
  typedef enum logic [1:0] {
    SCRUB_IDLE,
    SCRUB_READ,
    SCRUB_CHECK
  } scrub_state_e;

endpackage

`default_nettype wire

// File: rtl/ecc_scrubber.sv
/*
 * Walking ECC scrubber
 * Scrubs one word per trigger. Reads it in a free cycle, checks it the
 * cycle after and writes back a corrected codeword on a single error
 */

`default_nettype none

module ecc_scrubber (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 trigger_i,
  input  logic                 busy_i,          // Bus holds the array this cycle
  output logic                 req_o,
  output logic                 we_o,
  output tcdm_pkg::bank_addr_t addr_o,
  input  ecc_pkg::codeword_t   rdata_i,
  output ecc_pkg::codeword_t   wdata_o,
  output logic                 fix_o,
  output logic                 uncorrectable_o
);

  import tcdm_pkg::*;
  import ecc_pkg::*;

  scrub_state_e state_q, state_d;
  bank_addr_t   addr_q;          // Next word to scrub
  tcdm_data_t   fixed_data;
  logic         err_single;
  logic         err_multi;

  secded_decode i_decode (
    .code_i         ( rdata_i    ),
    .data_o         ( fixed_data ),
    .syndrome_o     (            ),
    .single_error_o ( err_single ),
    .multi_error_o  ( err_multi  )
  );

  // Clean re-encode also repairs a flipped check bit
  secded_encode i_encode (
    .data_i ( fixed_data ),
    .code_o ( wdata_o    )
  );

  always_comb begin
    state_d = state_q;
    req_o   = 1'b0;
    we_o    = 1'b0;
    unique case (state_q)
      SCRUB_IDLE:  if (trigger_i) state_d = SCRUB_READ;  // Triggers ignored elsewhere
      SCRUB_READ: begin
        req_o = ~busy_i;         // Wait for a cycle without bus traffic
        if (!busy_i) state_d = SCRUB_CHECK;
      end
      SCRUB_CHECK: begin
        req_o   = err_single;    // Write-back only for correctable words
        we_o    = err_single;
        state_d = SCRUB_IDLE;
      end
      default: state_d = SCRUB_IDLE;
    endcase
  end

  assign fix_o           = (state_q == SCRUB_CHECK) & err_single;
  assign uncorrectable_o = (state_q == SCRUB_CHECK) & err_multi;  // Word left as is
  assign addr_o          = addr_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= SCRUB_IDLE;
      addr_q  <= '0;
    end else begin
      state_q <= state_d;
      if (state_q == SCRUB_CHECK) addr_q <= addr_q + 1'b1;  // Wraps at BankSize
    end
  end

endmodule

`default_nettype wire

// File: rtl/ecc_sram_wrap.sv
/*
 * SECDED protected TCDM bank
 * Arbitrates the array between bus and scrubber, turns partial writes
 * into read-modify-write and injects codeword errors in test mode
 */

`default_nettype none

module ecc_sram_wrap (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 test_mode_i,
  input  ecc_pkg::codeword_t   flip_mask_i,
  // Bus port
  input  logic                 req_i,
  input  logic                 wen_i,         // Active low
  input  tcdm_pkg::bank_addr_t addr_i,
  input  tcdm_pkg::tcdm_be_t   be_i,
  input  tcdm_pkg::tcdm_data_t wdata_i,
  output logic                 gnt_o,
  output tcdm_pkg::tcdm_data_t rdata_o,
  // Error status of bus reads
  output logic                 single_error_o,
  output logic                 multi_error_o,
  // Scrubber
  input  logic                 scrub_trigger_i,
  output logic                 scrub_fix_o,
  output logic                 scrub_uncorrectable_o
);

  import tcdm_pkg::*;
  import ecc_pkg::*;

  ecc_state_e state_q, state_d;
  logic       bus_rd_q, bus_rd_d;  // Array output belongs to a bus read

  logic       sram_req, sram_we;
  bank_addr_t sram_addr;
  codeword_t  sram_wdata, sram_rdata;
  codeword_t  write_code;          // Before error injection

  tcdm_data_t enc_data, merged_data, dec_data;
  codeword_t  enc_code;
  logic       dec_single, dec_multi;

  logic       scrub_req, scrub_we, busy;
  bank_addr_t scrub_addr;
  codeword_t  scrub_wdata;

  // Merge enabled bytes into the corrected old word
  always_comb begin
    for (int unsigned b = 0; b < BeWidth; b++) begin
      merged_data[8*b +: 8] = be_i[b] ? wdata_i[8*b +: 8] : dec_data[8*b +: 8];
    end
  end

  assign enc_data = (state_q == RMW_MERGE) ? merged_data : wdata_i;

  secded_encode i_encode (
    .data_i ( enc_data ),
    .code_o ( enc_code )
  );

  // Shared by bus reads and the RMW old word
  secded_decode i_decode (
    .code_i         ( sram_rdata ),
    .data_o         ( dec_data   ),
    .syndrome_o     (            ),
    .single_error_o ( dec_single ),
    .multi_error_o  ( dec_multi  )
  );

  assign busy = req_i | (state_q == RMW_MERGE);

  ecc_scrubber i_scrubber (
    .clk_i           ( clk_i                 ),
    .rst_ni          ( rst_ni                ),
    .trigger_i       ( scrub_trigger_i       ),
    .busy_i          ( busy                  ),
    .req_o           ( scrub_req             ),
    .we_o            ( scrub_we              ),
    .addr_o          ( scrub_addr            ),
    .rdata_i         ( sram_rdata            ),
    .wdata_o         ( scrub_wdata           ),
    .fix_o           ( scrub_fix_o           ),
    .uncorrectable_o ( scrub_uncorrectable_o )
  );

  // Array arbitration, bus first
  always_comb begin
    state_d   = state_q;
    bus_rd_d  = 1'b0;
    gnt_o     = 1'b0;
    sram_req  = 1'b0;
    sram_we   = 1'b0;
    sram_addr = addr_i;
    unique case (state_q)
      IDLE: begin
        if (req_i) begin
          sram_req = 1'b1;
          if (wen_i) begin            // Read
            gnt_o    = 1'b1;
            bus_rd_d = 1'b1;
          end else if (&be_i) begin   // Full write
            gnt_o   = 1'b1;
            sram_we = 1'b1;
          end else begin              // Partial write, fetch old word first
            state_d = RMW_MERGE;
          end
        end else begin
          gnt_o = 1'b1;               // Nothing pending
          if (scrub_req) begin
            sram_req  = 1'b1;
            sram_addr = scrub_addr;
            state_d   = SCRUB_FIX;
          end
        end
      end
      RMW_MERGE: begin
        gnt_o    = 1'b1;              // Request retired with the merged write
        sram_req = 1'b1;
        sram_we  = 1'b1;
        state_d  = IDLE;
      end
      SCRUB_FIX: begin                // Bus held off while scrubber checks
        sram_req  = scrub_we;
        sram_we   = scrub_we;
        sram_addr = scrub_addr;
        state_d   = IDLE;
      end
      default: state_d = IDLE;
    endcase
  end

  assign write_code = (state_q == SCRUB_FIX) ? scrub_wdata : enc_code;
  assign sram_wdata = test_mode_i ? (write_code ^ flip_mask_i) : write_code;

  bank_sram i_bank (
    .clk_i   ( clk_i      ),
    .req_i   ( sram_req   ),
    .we_i    ( sram_we    ),
    .addr_i  ( sram_addr  ),
    .wdata_i ( sram_wdata ),
    .rdata_o ( sram_rdata )
  );

  assign rdata_o        = dec_data;
  assign single_error_o = bus_rd_q & dec_single;  // Aligned with read data
  assign multi_error_o  = bus_rd_q & dec_multi;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q  <= IDLE;
      bus_rd_q <= 1'b0;
    end else begin
      state_q  <= state_d;
      bus_rd_q <= bus_rd_d;
    end
  end

endmodule

`default_nettype wire

// File: rtl/secded_decode.sv
/*
 * Hsiao SECDED decoder
 * Recomputes the syndrome, corrects a single flipped data bit and
 * classifies the word as clean, single error or multiple error
 */

`default_nettype none

module secded_decode (
  input  ecc_pkg::codeword_t   code_i,
  output tcdm_pkg::tcdm_data_t data_o,
  output ecc_pkg::syndrome_t   syndrome_o,
  output logic                 single_error_o,
  output logic                 multi_error_o
);

  import tcdm_pkg::*;
  import ecc_pkg::*;

  syndrome_t  syndrome;
  tcdm_data_t data_fix;    // Data after correction
  logic       hit_data;    // Syndrome equals a data column
  logic       hit_check;   // Syndrome is a unit vector, check bit flipped
  logic       err_any;

  // Stored check bits xor the ones recomputed from the data
  always_comb begin
    syndrome = code_i[ProtectedWidth-1 -: CheckWidth];
    for (int unsigned j = 0; j < DataWidth; j++) begin
      if (code_i[j]) begin
        syndrome = syndrome ^ HsiaoCols[j];
      end
    end
  end

  // Column match flips the faulty data bit
  always_comb begin
    data_fix = code_i[DataWidth-1:0];
    hit_data = 1'b0;
    for (int unsigned j = 0; j < DataWidth; j++) begin
      if (syndrome == HsiaoCols[j]) begin
        data_fix[j] = ~data_fix[j];
        hit_data    = 1'b1;
      end
    end
  end

  assign err_any   = |syndrome;
  // Exactly one bit set, data left as read
  assign hit_check = err_any && ((syndrome & (syndrome - 1'b1)) == '0);

  // Even weight or unused odd column is uncorrectable
  assign single_error_o = hit_data | hit_check;
  assign multi_error_o  = err_any & ~(hit_data | hit_check);

  assign data_o     = data_fix;
  assign syndrome_o = syndrome;

endmodule

`default_nettype wire

// File: rtl/secded_encode.sv
/*
 * Hsiao SECDED encoder
 * Builds a 39-bit codeword from a 32-bit word: data kept as is in the
 * low bits, seven check bits on top. Purely combinational
 */

`default_nettype none

module secded_encode (
  input  tcdm_pkg::tcdm_data_t data_i,
  output ecc_pkg::codeword_t   code_o
);

  import tcdm_pkg::*;
  import ecc_pkg::*;

  syndrome_t check;  // Check bits under construction

  // Each set data bit toggles the check bits of its column
  // Equivalent to one parity tree per check bit
  always_comb begin
    check = '0;
    for (int unsigned j = 0; j < DataWidth; j++) begin
      if (data_i[j]) begin
        check = check ^ HsiaoCols[j];
      end
    end
  end

  // Systematic code, data bits pass straight through
  assign code_o = {check, data_i};

endmodule

`default_nettype wire

// File: rtl/tcdm_banks_wrap.sv
/*
 * Multi-bank ECC protected TCDM
 * NbBanks independent SECDED banks, each with its own bus port,
 * scrubber and response-id register
 */

`default_nettype none

module tcdm_banks_wrap #(
  parameter int unsigned NbBanks = 2
) (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  input  logic                                test_mode_i,
  input  ecc_pkg::codeword_t                  ecc_flip_mask_i,
  // Bus ports, one slice per bank
  input  logic                 [NbBanks-1:0]  req_i,
  input  logic                 [NbBanks-1:0]  wen_i,
  input  tcdm_pkg::tcdm_addr_t [NbBanks-1:0]  add_i,
  input  tcdm_pkg::tcdm_be_t   [NbBanks-1:0]  be_i,
  input  tcdm_pkg::tcdm_data_t [NbBanks-1:0]  data_i,
  input  tcdm_pkg::tcdm_id_t   [NbBanks-1:0]  id_i,
  output logic                 [NbBanks-1:0]  gnt_o,
  output tcdm_pkg::tcdm_data_t [NbBanks-1:0]  r_data_o,
  output tcdm_pkg::tcdm_id_t   [NbBanks-1:0]  r_id_o,
  // Scrubber and ECC status
  input  logic                 [NbBanks-1:0]  scrub_trigger_i,
  output logic                 [NbBanks-1:0]  scrub_fix_o,
  output logic                 [NbBanks-1:0]  scrub_uncorrectable_o,
  output logic                 [NbBanks-1:0]  ecc_single_error_o,
  output logic                 [NbBanks-1:0]  ecc_multiple_error_o
);

  import tcdm_pkg::*;

  for (genvar i = 0; i < NbBanks; i++) begin : gen_bank
    bank_addr_t word_idx;  // Byte address to word index
    tcdm_id_t   resp_id_q;

    assign word_idx = add_i[i][BankAddrW+1:2];

    // Id echoed every cycle, meaningful after an accepted read
    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        resp_id_q <= '0;
      end else begin
        resp_id_q <= id_i[i];
      end
    end
    assign r_id_o[i] = resp_id_q;

    ecc_sram_wrap i_ecc_bank (
      .clk_i                 ( clk_i                    ),
      .rst_ni                ( rst_ni                   ),
      .test_mode_i           ( test_mode_i              ),
      .flip_mask_i           ( ecc_flip_mask_i          ),
      .req_i                 ( req_i[i]                 ),
      .wen_i                 ( wen_i[i]                 ),
      .addr_i                ( word_idx                 ),
      .be_i                  ( be_i[i]                  ),
      .wdata_i               ( data_i[i]                ),
      .gnt_o                 ( gnt_o[i]                 ),
      .rdata_o               ( r_data_o[i]              ),
      .single_error_o        ( ecc_single_error_o[i]    ),
      .multi_error_o         ( ecc_multiple_error_o[i]  ),
      .scrub_trigger_i       ( scrub_trigger_i[i]       ),
      .scrub_fix_o           ( scrub_fix_o[i]           ),
      .scrub_uncorrectable_o ( scrub_uncorrectable_o[i] )
    );
  end

endmodule

`default_nettype wire

// File: rtl/tcdm_pkg.sv
/*
 * TCDM bus-side definitions
 * Widths and types of one bank port: byte address, data word,
 * byte enables, request id and the word index inside a bank
 */

`default_nettype none

package tcdm_pkg;

  // Bus widths
  localparam int unsigned AddrWidth = 32;
  localparam int unsigned DataWidth = 32;
  localparam int unsigned BeWidth   = DataWidth / 8;  // One enable per byte
  localparam int unsigned IdWidth   = 4;

  // Bank geometry
  localparam int unsigned BankSize  = 256;              // Words per bank
  localparam int unsigned BankAddrW = $clog2(BankSize); // Word index taken from add[9:2]

  // Byte address as seen on the port
  typedef logic [AddrWidth-1:0] tcdm_addr_t;

  // Unprotected data word
  typedef logic [DataWidth-1:0] tcdm_data_t;

  // Byte enables, bit b covers data[8b+7:8b]
  typedef logic [BeWidth-1:0] tcdm_be_t;

  // Request id, echoed one cycle later
  typedef logic [IdWidth-1:0] tcdm_id_t;

  // Word index inside one bank
  typedef logic [BankAddrW-1:0] bank_addr_t;

endpackage

`default_nettype wire

// File: tcdm_banks_wrap.f
rtl/tcdm_pkg.sv
rtl/ecc_pkg.sv
rtl/secded_encode.sv
rtl/secded_decode.sv
rtl/bank_sram.sv
rtl/ecc_scrubber.sv
rtl/ecc_sram_wrap.sv
rtl/tcdm_banks_wrap.sv
verification/tcdm_banks_tb.sv

// File: verification/tcdm_banks_tb.sv
/*
 * Testbench for the multi-bank ECC protected TCDM
 * Replays the records of the test data file on the bank ports and checks
 * read data, ECC flags, response ids and scrubber pulses
 */

`default_nettype none

module tcdm_banks_tb;

  timeunit 1ns;
  timeprecision 1ps;

  import tcdm_pkg::*;
  import ecc_pkg::*;

  localparam int unsigned NbBanks     = 2;
  localparam int unsigned ScrubWindow = 8;  // Cycles from one trigger to the next

  logic                       clk_i;
  logic                       rst_ni;
  logic                       test_mode;
  codeword_t                  flip_mask;
  logic       [NbBanks-1:0]   req, wen, gnt;
  tcdm_addr_t [NbBanks-1:0]   add;
  tcdm_be_t   [NbBanks-1:0]   be;
  tcdm_data_t [NbBanks-1:0]   wdata, r_data;
  tcdm_id_t   [NbBanks-1:0]   id, r_id;
  logic       [NbBanks-1:0]   scrub_trigger, scrub_fix, scrub_unc;
  logic       [NbBanks-1:0]   single_err, multi_err;

  // One entry per record of the data file
  string       rec_name[$];
  string       rec_op[$];
  int unsigned rec_bank[$];
  tcdm_addr_t  rec_addr[$];
  tcdm_be_t    rec_be[$];
  tcdm_data_t  rec_data[$];
  codeword_t   rec_flip[$];
  tcdm_id_t    rec_id[$];
  tcdm_data_t  rec_exp[$];
  logic [2:0]  rec_flags[$];  // Single or fix, multiple or uncorrectable, skip data

  int   errors;
  int   checks;
  logic loaded;

  tcdm_banks_wrap #(
    .NbBanks ( NbBanks )
  ) UUT (
    .clk_i                 ( clk_i         ),
    .rst_ni                ( rst_ni        ),
    .test_mode_i           ( test_mode     ),
    .ecc_flip_mask_i       ( flip_mask     ),
    .req_i                 ( req           ),
    .wen_i                 ( wen           ),
    .add_i                 ( add           ),
    .be_i                  ( be            ),
    .data_i                ( wdata         ),
    .id_i                  ( id            ),
    .gnt_o                 ( gnt           ),
    .r_data_o              ( r_data        ),
    .r_id_o                ( r_id          ),
    .scrub_trigger_i       ( scrub_trigger ),
    .scrub_fix_o           ( scrub_fix     ),
    .scrub_uncorrectable_o ( scrub_unc     ),
    .ecc_single_error_o    ( single_err    ),
    .ecc_multiple_error_o  ( multi_err     )
  );

  always #10 clk_i = ~clk_i;  // 20 ns period

  task automatic check_data(string name, string what, tcdm_data_t exp, tcdm_data_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("mismatch %s %s: expected %h, actual %h", name, what, exp, act);
    end
  endtask

  task automatic check_id(string name, tcdm_id_t exp, tcdm_id_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("mismatch %s r_id: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_flag(string name, string what, logic exp, logic act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("mismatch %s %s: expected %b, actual %b", name, what, exp, act);
    end
  endtask

  // One record per line with name op bank addr be data flip id exp flags
  // Lines starting with # are comments
  task automatic load_records();
    int          fd;
    int          n;
    int          c;
    logic        done;
    string       name;
    string       op;
    int unsigned bank;
    tcdm_addr_t  addr;
    tcdm_be_t    ben;
    tcdm_data_t  data;
    codeword_t   flip;
    tcdm_id_t    rid;
    tcdm_data_t  exp;
    logic [2:0]  flags;
    fd = $fopen("verification/tcdm_testdata.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("Could not open the test data file");
      return;
    end
    done = 1'b0;
    while (!done) begin
      n = $fscanf(fd, "%s", name);
      if (n != 1) begin
        done = 1'b1;
      end else if (name[0] == "#") begin
        c = $fgetc(fd);
        while (c != 'h0a && c != -1) c = $fgetc(fd);  // Drop rest of comment
      end else begin
        n = $fscanf(fd, " %s %d %h %h %h %h %h %h %h", op, bank, addr, ben, data, flip,
                    rid, exp, flags);
        if (n != 9) begin
          errors++;
          $display("Record %s in the test data file is incomplete", name);
          done = 1'b1;
        end else begin
          rec_name.push_back(name);
          rec_op.push_back(op);
          rec_bank.push_back(bank);
          rec_addr.push_back(addr);
          rec_be.push_back(ben);
          rec_data.push_back(data);
          rec_flip.push_back(flip);
          rec_id.push_back(rid);
          rec_exp.push_back(exp);
          rec_flags.push_back(flags);
        end
      end
    end
    $fclose(fd);
  endtask

  // Request held until a grant is seen and retired on the next rising edge
  task automatic issue_request(int unsigned idx, logic write, logic inject);
    int unsigned b;
    b = rec_bank[idx];
    @(posedge clk_i);
    req[b]    <= 1'b1;
    wen[b]    <= ~write;               // Active low
    add[b]    <= rec_addr[idx];
    be[b]     <= rec_be[idx];
    wdata[b]  <= rec_data[idx];
    id[b]     <= rec_id[idx];
    test_mode <= inject;
    flip_mask <= inject ? rec_flip[idx] : '0;
    @(negedge clk_i);
    while (gnt[b] !== 1'b1) @(negedge clk_i);  // Grant delay not assumed
    @(posedge clk_i);                           // Accepted here
    req[b]    <= 1'b0;
    id[b]     <= '0;                            // Echo must come from the register
    test_mode <= 1'b0;
    flip_mask <= '0;
  endtask

  task automatic read_and_check(int unsigned idx);
    int unsigned b;
    b = rec_bank[idx];
    issue_request(idx, 1'b0, 1'b0);
    @(negedge clk_i);  // Data, flags and id of the accepted read
    if (!rec_flags[idx][2]) check_data(rec_name[idx], "data", rec_exp[idx], r_data[b]);
    check_flag(rec_name[idx], "single", rec_flags[idx][0], single_err[b]);
    check_flag(rec_name[idx], "multiple", rec_flags[idx][1], multi_err[b]);
    check_id(rec_name[idx], rec_id[idx], r_id[b]);
  endtask

  // One trigger pulse and a count of scrubber pulses up to the next trigger slot
  task automatic scrub_step(int unsigned idx);
    int unsigned b;
    int          fix_cnt;
    int          unc_cnt;
    b       = rec_bank[idx];
    fix_cnt = 0;
    unc_cnt = 0;
    @(posedge clk_i);
    scrub_trigger[b] <= 1'b1;
    @(posedge clk_i);
    scrub_trigger[b] <= 1'b0;
    repeat (ScrubWindow - 1) begin
      @(negedge clk_i);
      if (scrub_fix[b] === 1'b1) fix_cnt++;
      if (scrub_unc[b] === 1'b1) unc_cnt++;
    end
    if (fix_cnt > 1 || unc_cnt > 1) begin
      errors++;
      $display("%s: more than one scrubber pulse after a single trigger", rec_name[idx]);
    end
    check_flag(rec_name[idx], "scrub_fix", rec_flags[idx][0], fix_cnt != 0);
    check_flag(rec_name[idx], "scrub_uncorrectable", rec_flags[idx][1], unc_cnt != 0);
  endtask

  initial begin : stimulus
    clk_i         = 1'b0;
    rst_ni        = 1'b0;
    test_mode     = 1'b0;
    flip_mask     = '0;
    req           = '0;
    wen           = '1;
    add           = '0;
    be            = '0;
    wdata         = '0;
    id            = '0;
    scrub_trigger = '0;
    errors        = 0;
    checks        = 0;
    loaded        = 1'b0;
    load_records();
    if (rec_name.size() == 0) begin
      errors++;
      $display("No test records were read");
    end
    loaded = 1'b1;
    repeat (16) @(posedge clk_i);
    rst_ni <= 1'b1;
    foreach (rec_name[i]) begin
      if (rec_op[i] == "W") begin
        issue_request(i, 1'b1, 1'b0);
      end else if (rec_op[i] == "INJ") begin
        issue_request(i, 1'b1, 1'b1);  // Stored codeword gets the flip mask
      end else if (rec_op[i] == "R") begin
        read_and_check(i);
      end else if (rec_op[i] == "SCRUB") begin
        scrub_step(i);
      end else begin
        errors++;
        $display("%s: unknown operation %s", rec_name[i], rec_op[i]);
      end
    end
    repeat (4) @(posedge clk_i);
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

  // Budget of 10 cycles per record on top of reset and slack
  initial begin : watchdog
    wait (loaded === 1'b1);
    repeat (rec_name.size() * 10 + 200) @(posedge clk_i);
    $display("Timeout: the run did not complete in %0d cycles", rec_name.size() * 10 + 200);
    $display("Checks: %0d, errors: %0d", checks, errors + 1);
    $display("Finished with errors");
    $finish;
  end

endmodule

`default_nettype wire

// File: verification/tcdm_testdata.txt
# name op bank byte_addr be data flip_mask id exp_data flags (all numbers hex, bank decimal)
# flags: bit0 single error or scrub fix, bit1 multiple error or uncorrectable, bit2 data unchecked
wr_b0_w0     W     0 00000000 f 01234567 0000000000 0 00000000 0
wr_b0_w1     W     0 00000004 f 89abcdef 0000000000 0 00000000 0
wr_b0_w2     W     0 00000008 f deadbeef 0000000000 0 00000000 0
wr_b1_w0     W     1 00000000 f cafef00d 0000000000 0 00000000 0
wr_b1_w1     W     1 00000004 f 0badc0de 0000000000 0 00000000 0
wr_b1_w2     W     1 00000008 f 13579bdf 0000000000 0 00000000 0
rd_b0_w0     R     0 00000000 f 00000000 0000000000 1 01234567 0
rd_b1_w0     R     1 00000000 f 00000000 0000000000 2 cafef00d 0
wr_b0_w4     W     0 00000010 f 11223344 0000000000 0 00000000 0
pw_b0_w4_lo  W     0 00000010 5 aabbccdd 0000000000 0 00000000 0
rd_b0_w4_lo  R     0 00000010 f 00000000 0000000000 3 11bb33dd 0
pw_b0_w4_hi  W     0 00000010 8 5a000000 0000000000 0 00000000 0
rd_b0_w4_hi  R     0 00000010 f 00000000 0000000000 4 5abb33dd 0
pw_b1_w1     W     1 00000004 3 ffff1234 0000000000 0 00000000 0
rd_b1_w1_pw  R     1 00000004 f 00000000 0000000000 5 0bad1234 0
inj1_b0_w5   INJ   0 00000014 f 600dcafe 0000000020 0 00000000 0
rd_b0_w5     R     0 00000014 f 00000000 0000000000 6 600dcafe 1
pw_b0_w5     W     0 00000014 1 000000ff 0000000000 0 00000000 0
rd_b0_w5_pw  R     0 00000014 f 00000000 0000000000 7 600dcaff 0
inj1_b1_w5   INJ   1 00000014 f 76543210 0800000000 0 00000000 0
rd_b1_w5     R     1 00000014 f 00000000 0000000000 8 76543210 1
inj2_b0_w6   INJ   0 00000018 f 12121212 0000000003 0 00000000 0
rd_b0_w6     R     0 00000018 f 00000000 0000000000 9 00000000 6
inj1_b0_w3   INJ   0 0000000c f a5a5a5a5 0000040000 0 00000000 0
scrub_b0_1   SCRUB 0 00000000 0 00000000 0000000000 0 00000000 0
scrub_b0_2   SCRUB 0 00000000 0 00000000 0000000000 0 00000000 0
scrub_b0_3   SCRUB 0 00000000 0 00000000 0000000000 0 00000000 0
scrub_b0_4   SCRUB 0 00000000 0 00000000 0000000000 0 00000000 1
rd_b0_w3     R     0 0000000c f 00000000 0000000000 a a5a5a5a5 0
inj2_b1_w3   INJ   1 0000000c f 3c3c3c3c 0000000c00 0 00000000 0
scrub_b1_1   SCRUB 1 00000000 0 00000000 0000000000 0 00000000 0
scrub_b1_2   SCRUB 1 00000000 0 00000000 0000000000 0 00000000 0
scrub_b1_3   SCRUB 1 00000000 0 00000000 0000000000 0 00000000 0
scrub_b1_4   SCRUB 1 00000000 0 00000000 0000000000 0 00000000 2
rd_b1_w3     R     1 0000000c f 00000000 0000000000 b 00000000 6
